// File: flist.f
verilog/ooo_config_pkg.sv
verilog/ooo_types_pkg.sv
verilog/rename_map.sv
verilog/phys_reg_file.sv
verilog/reorder_buffer.sv
verilog/retire.sv
verilog/ooo_commit_top.sv
verif/ooo_commit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile the commit-end testbench with Verilator, run it, and judge the log
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal --top-module ooo_commit_tb \
    -f flist.f --Mdir "$build_dir" -o ooo_commit_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$build_dir/ooo_commit_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '*** TEST PASSED ***' "$log_file"; then
    exit 0
fi
echo "Pass message not found in $log_file"
exit 1

// File: verif/ooo_commit_tb.sv
`default_nettype none

module ooo_commit_tb;

    import ooo_types_pkg::*;

    localparam int retire_width = ooo_config_pkg::retire_width;
    localparam int free_at_idle = ooo_config_pkg::num_phys_regs - ooo_config_pkg::num_arch_regs;
    // Accepted instructions before dispatch_ready falls with no writebacks
    localparam int fill_limit = ooo_config_pkg::rob_depth < free_at_idle ?
                                ooo_config_pkg::rob_depth : free_at_idle;

    // One accepted instruction as the reference model tracks it
    typedef struct packed {
        dispatch_packet inst;
        phys_reg_idx    tag;      // Dispatch_tag given at acceptance
        data_word       data;     // Value written back to the tag
        logic           written;  // Writeback has reached the register file
    } flight_entry;

    logic                            clock;
    logic                            reset;
    logic                            dispatch_valid;
    dispatch_packet                  dispatch_inst;
    logic                            dispatch_ready;
    phys_reg_idx                     dispatch_tag;
    writeback_packet                 writeback;
    commit_packet [retire_width-1:0] committed_insts;

    flight_entry in_flight [$];     // Program order with the oldest first
    phys_reg_idx pending_tags [$];  // Accepted but not yet written back
    logic [31:0] lfsr_state = 32'd44;
    logic        dispatch_enable;
    logic        writeback_enable;
    logic        last_fire;
    logic        halt_seen;
    int          gen_count;
    int          gen_limit;
    int          halt_index;
    int          fire_count;
    int          commit_count;

    ooo_commit_top u_ooo_commit_top (
        .clock           (clock),
        .reset           (reset),
        .dispatch_valid  (dispatch_valid),
        .dispatch_inst   (dispatch_inst),
        .dispatch_ready  (dispatch_ready),
        .dispatch_tag    (dispatch_tag),
        .writeback       (writeback),
        .committed_insts (committed_insts)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Galois LFSR stepped once for every bit handed out
    function automatic logic [31:0] lfsr_bits(input int width);
        logic [31:0] value;
        logic        out_bit;
        value = '0;
        for (int i = 0; i < width; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) lfsr_state = lfsr_state ^ 32'hA300_0000;  // Taps 32, 30, 26, 25
            value = {value[30:0], out_bit};
        end
        return value;
    endfunction

    function automatic dispatch_packet random_inst(input logic make_halt);
        dispatch_packet inst;
        inst.npc      = lfsr_bits(32);
        inst.dest_reg = arch_reg_idx'(lfsr_bits(5));
        inst.has_dest = lfsr_bits(1) != 0;
        inst.halt     = make_halt;
        inst.illegal  = lfsr_bits(3) == 0;  // About one in eight
        return inst;
    endfunction

    // Reference model for the commit record that one instruction owes
    function automatic commit_packet expected_commit(input flight_entry entry);
        commit_packet rec;
        rec.valid   = 1'b1;
        rec.npc     = entry.inst.npc;
        rec.reg_idx = entry.inst.dest_reg;  // Reported even without a destination
        rec.data    = entry.data;
        rec.halt    = entry.inst.halt;
        rec.illegal = entry.inst.illegal;
        return rec;
    endfunction

    // Longest written prefix of the oldest instructions, closed by a halt and capped at N
    function automatic int expected_commit_count();
        int n;
        n = 0;
        if (halt_seen) return 0;
        while (n < retire_width && n < in_flight.size() && in_flight[n].written) begin
            n++;
            if (in_flight[n - 1].inst.halt) return n;
        end
        return n;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            abort_run($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, got, want));
        end
    endtask

    task automatic compare_commit(input int slot, input commit_packet got);
        flight_entry  oldest;
        commit_packet want;
        if (in_flight.size() == 0) abort_run("A commit appeared with nothing in flight");
        oldest = in_flight.pop_front();
        if (!oldest.written) abort_run("An instruction committed before its writeback was visible");
        want = expected_commit(oldest);
        check_value($sformatf("committed_insts[%0d].npc", slot), got.npc, want.npc);
        check_value($sformatf("committed_insts[%0d].reg_idx", slot), 32'(got.reg_idx),
                    32'(want.reg_idx));
        check_value($sformatf("committed_insts[%0d].data", slot), got.data, want.data);
        check_value($sformatf("committed_insts[%0d].halt", slot), 32'(got.halt), 32'(want.halt));
        check_value($sformatf("committed_insts[%0d].illegal", slot), 32'(got.illegal),
                    32'(want.illegal));
    endtask

    // Compare process that reads the values that were stable before this edge
    always @(posedge clock) begin : commit_monitor
        logic        gap;
        int          found;
        int          want_count;
        int          got_count;
        flight_entry entry;
        if (reset) begin
            last_fire = 1'b0;
        end else begin
            gap        = 1'b0;
            got_count  = 0;
            want_count = expected_commit_count();  // Model state before this edge's commits
            for (int i = 0; i < retire_width; i++) begin
                if (!committed_insts[i].valid) begin
                    gap = 1'b1;
                end else begin
                    if (gap) abort_run("Valid commit slots are not contiguous from slot 0");
                    if (halt_seen) abort_run("An instruction committed after a halt");
                    compare_commit(i, committed_insts[i]);
                    commit_count++;
                    got_count++;
                    halt_seen = halt_seen | committed_insts[i].halt;
                end
            end
            check_value("committed_insts valid count", got_count, want_count);
            if (halt_seen && dispatch_ready) abort_run("dispatch_ready is high after a halt");
            last_fire = dispatch_valid && dispatch_ready;
            if (last_fire) begin
                foreach (in_flight[i]) begin
                    if (in_flight[i].tag == dispatch_tag) abort_run("A tag in flight was reissued");
                end
                entry = '{inst: dispatch_inst, tag: dispatch_tag, data: '0, written: 1'b0};
                in_flight.push_back(entry);
                pending_tags.push_back(dispatch_tag);
                fire_count++;
            end
            if (writeback.valid) begin
                found = -1;
                foreach (in_flight[i]) begin
                    if (in_flight[i].tag == writeback.t_new && !in_flight[i].written) found = i;
                end
                if (found < 0) abort_run("A writeback matched no instruction in flight");
                in_flight[found].data    = writeback.data;
                in_flight[found].written = 1'b1;
            end
        end
    end

    // Stimulus on the falling edge with writebacks in random order among pending tags
    always @(negedge clock) begin : stimulus_driver
        int pick;
        if (!reset) begin
            if (dispatch_valid && !last_fire) begin
                dispatch_valid = 1'b1;  // Not accepted yet, so the same instruction stays
            end else if (dispatch_enable && gen_count != gen_limit && lfsr_bits(2) != 0) begin
                dispatch_inst  = random_inst(gen_count == halt_index);
                dispatch_valid = 1'b1;
                gen_count++;
            end else begin
                dispatch_valid = 1'b0;
            end
            if (writeback_enable && pending_tags.size() != 0 && lfsr_bits(1) != 0) begin
                pick            = int'(lfsr_bits(6)) % pending_tags.size();
                writeback.valid = 1'b1;
                writeback.t_new = pending_tags[pick];
                writeback.data  = lfsr_bits(32);
                pending_tags.delete(pick);
            end else begin
                writeback = '0;
            end
        end
    end

    task automatic wait_cycle();
        @(posedge clock);
        #1;  // Past the edge, so the monitor has finished its bookkeeping
    endtask

    task automatic drain_pipeline(input int limit);
        int cycles;
        dispatch_enable  = 1'b0;
        writeback_enable = 1'b1;
        cycles           = 0;
        while (in_flight.size() != 0 || dispatch_valid) begin
            if (cycles == limit) abort_run("Timeout while draining the reorder buffer");
            wait_cycle();
            cycles++;
        end
        check_value("commit count", commit_count, fire_count);
    endtask

    initial begin : main_sequence
        int cycles;
        int base;
        reset            = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch_inst    = '0;
        writeback        = '0;
        dispatch_enable  = 1'b0;
        writeback_enable = 1'b0;
        halt_seen        = 1'b0;
        gen_count        = 0;
        gen_limit        = 0;
        halt_index       = -1;  // No halt until the last phase
        fire_count       = 0;
        commit_count     = 0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        wait_cycle();
        check_value("dispatch_ready", 32'(dispatch_ready), 32'd1);
        for (int i = 0; i < retire_width; i++) begin
            check_value($sformatf("committed_insts[%0d].valid", i),
                        32'(committed_insts[i].valid), 0);
        end
        // Long random run that cycles through the physical registers several times
        gen_limit        = 300;
        dispatch_enable  = 1'b1;
        writeback_enable = 1'b1;
        cycles           = 0;
        while (gen_count != gen_limit) begin
            if (cycles == 4000) abort_run("Timeout in the random dispatch run");
            wait_cycle();
            cycles++;
        end
        drain_pipeline(2000);
        // Withhold writebacks until the reorder buffer or the free list runs out
        base             = fire_count;
        writeback_enable = 1'b0;
        gen_limit        = gen_count + 1000;
        dispatch_enable  = 1'b1;
        cycles           = 0;
        while (dispatch_ready) begin
            if (cycles == 200) abort_run("dispatch_ready never fell with writebacks withheld");
            wait_cycle();
            cycles++;
        end
        check_value("accepted before back-pressure", fire_count - base, fill_limit);
        repeat (10) begin
            wait_cycle();
            check_value("dispatch_ready", 32'(dispatch_ready), 32'd0);
            check_value("accepted before back-pressure", fire_count - base, fill_limit);
        end
        drain_pipeline(1000);
        // The halt is the fourth of eight, and all eight are accepted before any writeback
        base             = fire_count;
        halt_index       = gen_count + 3;
        gen_limit        = gen_count + 8;
        dispatch_enable  = 1'b1;
        writeback_enable = 1'b0;
        cycles           = 0;
        while (fire_count - base != 8) begin
            if (cycles == 200) abort_run("Timeout while dispatching the halt group");
            wait_cycle();
            cycles++;
        end
        // Younger instructions sit behind the halt and complete along with it
        writeback_enable = 1'b1;
        cycles           = 0;
        while (!halt_seen || pending_tags.size() != 0) begin
            if (cycles == 500) abort_run("Timeout waiting for the halt to commit");
            wait_cycle();
            cycles++;
        end
        // Everything younger is complete now, yet nothing may commit or dispatch
        repeat (20) wait_cycle();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/ooo_commit_top.sv
`default_nettype none

module ooo_commit_top #(
    parameter int retire_width  = ooo_config_pkg::retire_width,
    parameter int rob_depth     = ooo_config_pkg::rob_depth,
    parameter int num_arch_regs = ooo_config_pkg::num_arch_regs,
    parameter int num_phys_regs = ooo_config_pkg::num_phys_regs
) (
    input  logic                                           clock,
    input  logic                                           reset,
    input  logic                                           dispatch_valid,
    input  ooo_types_pkg::dispatch_packet                  dispatch_inst,
    output logic                                           dispatch_ready,
    output ooo_types_pkg::phys_reg_idx                     dispatch_tag,    // Use it for writeback
    input  ooo_types_pkg::writeback_packet                 writeback,
    output ooo_types_pkg::commit_packet [retire_width-1:0] committed_insts
);

    import ooo_types_pkg::*;

    localparam int cnt_bits = $clog2(retire_width + 1);

    logic                              dispatch_fire;
    logic                              rob_full;
    logic                              free_available;
    logic                              halted;
    phys_reg_idx                       alloc_reg;
    phys_reg_idx                       prev_map;
    rob_packet                         push_entry;
    rob_packet   [retire_width-1:0]    head_entries;
    logic        [cnt_bits-1:0]        head_count;
    logic        [cnt_bits-1:0]        num_retiring;
    logic        [cnt_bits-1:0]        freed_count;
    phys_reg_idx [retire_width-1:0]    freed_regs;
    phys_reg_idx [retire_width-1:0]    read_regs;
    data_word    [retire_width-1:0]    read_data;
    logic        [retire_width-1:0]    read_complete;

    // Room in the buffer, a register to hand out, and no halt yet
    assign dispatch_ready = !rob_full && free_available && !halted;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;
    assign dispatch_tag   = alloc_reg;

    assign push_entry = '{inst: dispatch_inst, t_new: alloc_reg, t_old: prev_map};

    rename_map #(
        .retire_width  (retire_width),
        .num_arch_regs (num_arch_regs),
        .num_phys_regs (num_phys_regs)
    ) u_rename_map (
        .clock          (clock),
        .reset          (reset),
        .dispatch_fire  (dispatch_fire),
        .dest_reg       (dispatch_inst.dest_reg),
        .has_dest       (dispatch_inst.has_dest),
        .alloc_reg      (alloc_reg),
        .prev_map       (prev_map),
        .free_available (free_available),
        .freed_regs     (freed_regs),
        .freed_count    (freed_count)
    );

    phys_reg_file #(
        .retire_width  (retire_width),
        .num_phys_regs (num_phys_regs)
    ) u_phys_reg_file (
        .clock         (clock),
        .reset         (reset),
        .writeback     (writeback),
        .alloc_fire    (dispatch_fire),
        .alloc_reg     (alloc_reg),
        .read_regs     (read_regs),
        .read_data     (read_data),
        .read_complete (read_complete)
    );

    reorder_buffer #(
        .retire_width (retire_width),
        .rob_depth    (rob_depth)
    ) u_reorder_buffer (
        .clock        (clock),
        .reset        (reset),
        .push_valid   (dispatch_fire),
        .push_entry   (push_entry),
        .full         (rob_full),
        .head_entries (head_entries),
        .head_count   (head_count),
        .num_retiring (num_retiring)
    );

    retire #(
        .retire_width (retire_width)
    ) u_retire (
        .clock           (clock),
        .reset           (reset),
        .head_entries    (head_entries),
        .head_count      (head_count),
        .read_regs       (read_regs),
        .read_data       (read_data),
        .read_complete   (read_complete),
        .num_retiring    (num_retiring),
        .freed_regs      (freed_regs),
        .freed_count     (freed_count),
        .committed_insts (committed_insts),
        .halted          (halted)
    );

endmodule

`default_nettype wire

// File: verilog/retire.sv
`default_nettype none

module retire #(
    parameter int retire_width = ooo_config_pkg::retire_width
) (
    input  logic                                           clock,
    input  logic                                           reset,
    input  ooo_types_pkg::rob_packet    [retire_width-1:0] head_entries,
    input  logic [$clog2(retire_width+1)-1:0]              head_count,
    output ooo_types_pkg::phys_reg_idx  [retire_width-1:0] read_regs,      // Register file addresses
    input  ooo_types_pkg::data_word     [retire_width-1:0] read_data,
    input  logic                        [retire_width-1:0] read_complete,
    output logic [$clog2(retire_width+1)-1:0]              num_retiring,   // Pop count for the buffer
    output ooo_types_pkg::phys_reg_idx  [retire_width-1:0] freed_regs,     // Back to the free list
    output logic [$clog2(retire_width+1)-1:0]              freed_count,
    output ooo_types_pkg::commit_packet [retire_width-1:0] committed_insts,
    output logic                                           halted          // Halt done or committing
);

    import ooo_types_pkg::*;

    logic halt_q;       // A halt has been committed in an earlier cycle
    logic halt_commit;  // A halt commits in this cycle
    logic stop;         // Scan has hit the end of the committable prefix

    always_comb begin
        for (int i = 0; i < retire_width; i++) begin
            read_regs[i] = head_entries[i].t_new;  // Completion is tracked on T_new
        end
    end

    // Commit the longest completed prefix, ending after the first halt
    always_comb begin
        num_retiring    = '0;
        freed_regs      = '0;
        committed_insts = '0;
        halt_commit     = 1'b0;
        stop            = halt_q;
        for (int i = 0; i < retire_width; i++) begin
            if (!stop && i < int'(head_count) && read_complete[i]) begin
                committed_insts[i].valid   = 1'b1;
                committed_insts[i].npc     = head_entries[i].inst.npc;
                committed_insts[i].reg_idx = head_entries[i].inst.dest_reg;
                committed_insts[i].data    = read_data[i];
                committed_insts[i].halt    = head_entries[i].inst.halt;
                committed_insts[i].illegal = head_entries[i].inst.illegal;
                // The older mapping dies here, or T_new itself when nothing was written
                freed_regs[i] = head_entries[i].inst.has_dest ? head_entries[i].t_old
                                                              : head_entries[i].t_new;
                num_retiring  = num_retiring + 1'b1;
                halt_commit   = halt_commit | head_entries[i].inst.halt;
                stop          = head_entries[i].inst.halt;  // Nothing younger may pass a halt
            end else begin
                stop = 1'b1;
            end
        end
    end

    assign freed_count = num_retiring;         // One freed register per committed slot
    assign halted      = halt_q | halt_commit;  // Closes dispatch in the halt's own cycle

    always_ff @(posedge clock) begin
        if (reset) begin
            halt_q <= 1'b0;
        end else if (halt_commit) begin
            halt_q <= 1'b1;  // Sticky until reset
        end
    end

endmodule

`default_nettype wire

// File: verilog/reorder_buffer.sv
`default_nettype none

module reorder_buffer #(
    parameter int retire_width = ooo_config_pkg::retire_width,
    parameter int rob_depth    = ooo_config_pkg::rob_depth
) (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        push_valid,    // One instruction in
    input  ooo_types_pkg::rob_packet                    push_entry,
    output logic                                        full,
    output ooo_types_pkg::rob_packet [retire_width-1:0] head_entries,  // Slot 0 is the oldest
    output logic [$clog2(retire_width+1)-1:0]           head_count,    // Valid head slots
    input  logic [$clog2(retire_width+1)-1:0]           num_retiring   // Entries leaving now
);

    import ooo_types_pkg::*;

    localparam int ptr_bits = $clog2(rob_depth);
    localparam int cnt_bits = $clog2(rob_depth + 1);
    localparam int hc_bits  = $clog2(retire_width + 1);

    rob_packet           entries [rob_depth];
    logic [ptr_bits-1:0] head;   // Oldest entry
    logic [ptr_bits-1:0] tail;   // Next slot to write
    logic [cnt_bits-1:0] count;  // Occupied entries

    // Pointer arithmetic that also works for a depth that is not a power of two
    function automatic logic [ptr_bits-1:0] wrap(input int pos);
        return ptr_bits'(pos >= rob_depth ? pos - rob_depth : pos);
    endfunction

    assign full = (count == cnt_bits'(rob_depth));

    always_comb begin
        // Slots past count are ignored downstream
        for (int i = 0; i < retire_width; i++) begin
            head_entries[i] = entries[wrap(int'(head) + i)];
        end
        if (int'(count) > retire_width) begin
            head_count = hc_bits'(retire_width);
        end else begin
            head_count = hc_bits'(count);
        end
    end

    // Payload storage is written only at the tail
    always_ff @(posedge clock) begin
        if (push_valid) begin
            entries[tail] <= push_entry;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push_valid) begin
                tail <= wrap(int'(tail) + 1);
            end
            head  <= wrap(int'(head) + int'(num_retiring));
            // Push and pop together
            count <= count + cnt_bits'(push_valid) - cnt_bits'(num_retiring);
        end
    end

endmodule

`default_nettype wire

// File: verilog/phys_reg_file.sv
`default_nettype none

module phys_reg_file #(
    parameter int retire_width  = ooo_config_pkg::retire_width,
    parameter int num_phys_regs = ooo_config_pkg::num_phys_regs
) (
    input  logic                                          clock,
    input  logic                                          reset,
    input  ooo_types_pkg::writeback_packet                writeback,
    input  logic                                          alloc_fire,     // Dispatch transfer
    input  ooo_types_pkg::phys_reg_idx                    alloc_reg,      // Register being handed out
    input  ooo_types_pkg::phys_reg_idx [retire_width-1:0] read_regs,      // One per retire slot
    output ooo_types_pkg::data_word    [retire_width-1:0] read_data,
    output logic                       [retire_width-1:0] read_complete
);

    import ooo_types_pkg::*;

    data_word                 data_array [num_phys_regs];
    logic [num_phys_regs-1:0] complete_bits;  // Value is present for the register

    // Read ports see the state as of the last edge, so a writeback shows one cycle later
    always_comb begin
        for (int i = 0; i < retire_width; i++) begin
            read_data[i]     = data_array[read_regs[i]];
            read_complete[i] = complete_bits[read_regs[i]];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // Initial architectural state is all zero and already available
            complete_bits <= '1;
            for (int i = 0; i < num_phys_regs; i++) begin
                data_array[i] <= '0;
            end
        end else begin
            if (alloc_fire) begin
                complete_bits[alloc_reg] <= 1'b0;  // New owner has not produced a value yet
            end
            if (writeback.valid) begin
                data_array[writeback.t_new]    <= writeback.data;
                complete_bits[writeback.t_new] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/rename_map.sv
`default_nettype none

module rename_map #(
    parameter int retire_width  = ooo_config_pkg::retire_width,
    parameter int num_arch_regs = ooo_config_pkg::num_arch_regs,
    parameter int num_phys_regs = ooo_config_pkg::num_phys_regs
) (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          dispatch_fire,  // Transfer this cycle
    input  ooo_types_pkg::arch_reg_idx                    dest_reg,
    input  logic                                          has_dest,
    output ooo_types_pkg::phys_reg_idx                    alloc_reg,      // Lowest free register
    output ooo_types_pkg::phys_reg_idx                    prev_map,       // Becomes T_old
    output logic                                          free_available,
    input  ooo_types_pkg::phys_reg_idx [retire_width-1:0] freed_regs,     // From retire
    input  logic [$clog2(retire_width+1)-1:0]             freed_count
);

    import ooo_types_pkg::*;

    phys_reg_idx              map_table [num_arch_regs];  // Current arch to phys mapping
    logic [num_phys_regs-1:0] free_bits;                  // High means the register is free

    // Priority encoder scanned from the top so the lowest free index wins
    always_comb begin
        alloc_reg      = '0;
        free_available = 1'b0;
        for (int i = num_phys_regs - 1; i >= 0; i--) begin
            if (free_bits[i]) begin
                alloc_reg      = phys_reg_idx'(i);
                free_available = 1'b1;
            end
        end
    end

    assign prev_map = map_table[dest_reg];  // Read before the update at this edge

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_arch_regs; i++) begin
                map_table[i] <= phys_reg_idx'(i);  // Identity mapping out of reset
            end
            for (int i = 0; i < num_phys_regs; i++) begin
                free_bits[i] <= (i >= num_arch_regs);
            end
        end else begin
            if (dispatch_fire && has_dest) begin
                map_table[dest_reg] <= alloc_reg;
            end
            // Registers released by retire are all busy now, so they never collide with alloc_reg
            for (int i = 0; i < retire_width; i++) begin
                if (i < int'(freed_count)) begin
                    free_bits[freed_regs[i]] <= 1'b1;
                end
            end
            if (dispatch_fire) begin
                free_bits[alloc_reg] <= 1'b0;  // Taken by the dispatched instruction
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/ooo_types_pkg.sv
`default_nettype none

// Records that travel between rename, reorder buffer, writeback and retire
package ooo_types_pkg;

    import ooo_config_pkg::*;

    typedef logic [31:0]              data_word;     // One register value
    typedef logic [phys_idx_bits-1:0] phys_reg_idx;  // Physical register tag
    typedef logic [arch_idx_bits-1:0] arch_reg_idx;  // Architectural register number

    // What the front end hands over for one instruction
    typedef struct packed {
        logic [31:0] npc;       // Address of the next instruction
        arch_reg_idx dest_reg;  // Destination, meaningful only with has_dest
        logic        has_dest;
        logic        halt;      // Stops the machine once committed
        logic        illegal;   // Carried through to the commit record
    } dispatch_packet;

    // One reorder buffer slot
    typedef struct packed {
        dispatch_packet inst;
        phys_reg_idx    t_new;  // Register given at rename, tracks completion
        phys_reg_idx    t_old;  // Previous mapping of dest_reg
    } rob_packet;

    typedef struct packed {
        logic        valid;
        phys_reg_idx t_new;  // Register being completed
        data_word    data;
    } writeback_packet;

    // One committed instruction as the outside sees it
    typedef struct packed {
        logic        valid;
        logic [31:0] npc;
        arch_reg_idx reg_idx;
        data_word    data;
        logic        halt;
        logic        illegal;
    } commit_packet;

endpackage

`default_nettype wire

// File: verilog/ooo_config_pkg.sv
`default_nettype none

// Default sizes of the commit end of the core
package ooo_config_pkg;

    localparam int retire_width  = 4;   // Most instructions committed in one cycle
    localparam int rob_depth     = 16;  // Reorder buffer entries
    localparam int num_arch_regs = 32;  // Architectural registers seen by software
    localparam int num_phys_regs = 64;  // Physical registers behind the map table

    // Index widths follow from the register counts
    localparam int phys_idx_bits = $clog2(num_phys_regs);
    localparam int arch_idx_bits = $clog2(num_arch_regs);

endpackage

`default_nettype wire
